/* hdl/soc_boot_defines.svh */
// Widths, memory depth and synchronizer length for the boot slice
// Boot base addresses of the ROM, ICCM and QSPI regions

`ifndef SOC_BOOT_DEFINES_SVH
`define SOC_BOOT_DEFINES_SVH

// ICCM geometry
`define ICCM_AW        13
`define WORD_W         32
`define MASK_W         4
`define ICCM_DEPTH     8192

// Flops on each housekeeping SPI pin
`define HK_SYNC_STAGES 2

// Boot map
`define BOOT_ROM_BASE  32'h0001_0000
`define BOOT_ICCM_BASE 32'h2000_0000
`define BOOT_QSPI_BASE 32'h9000_0000

`endif

/* hdl/iccm_bus_pkg.sv */
// ICCM bus types
// Address, data, mask and boot address vectors, and the memory request struct
`default_nettype none

`include "soc_boot_defines.svh"

package iccm_bus_pkg;

  // Word address into the ICCM
  typedef logic [`ICCM_AW-1:0] iccm_addr_t;

  // Data word and its byte enables
  typedef logic [`WORD_W-1:0]  word_t;
  typedef logic [`MASK_W-1:0]  wmask_t;

  // Processor start address
  typedef logic [31:0]         boot_addr_t;

  // One memory access, 50 bits
  typedef struct packed {
    logic       we;
    iccm_addr_t addr;
    word_t      wdata;
    wmask_t     wmask;
  } mem_req_t;

endpackage

`default_nettype wire

/* hdl/boot_ctrl_pkg.sv */
// Boot control types
// Loader state encoding and boot source encoding
`default_nettype none

package boot_ctrl_pkg;

  // Housekeeping SPI loader states
  typedef enum logic [1:0] {
    HK_IDLE   = 2'd0,
    HK_SHIFT  = 2'd1,
    HK_COMMIT = 2'd2
  } hk_state_e;

  // Where the core starts fetching
  typedef enum logic [1:0] {
    BOOT_ROM  = 2'd0,
    BOOT_ICCM = 2'd1,
    BOOT_QSPI = 2'd2
  } boot_src_e;

endpackage

`default_nettype wire

/* hdl/hk_spi_loader.sv */
// Housekeeping SPI loader
// Pin synchronizers, word assembly, ICCM write strobes and done flag
`default_nettype none

`include "soc_boot_defines.svh"

module hk_spi_loader (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   hk_sck_i,
  input  logic                   hk_sdi_i,
  input  logic                   hk_csb_i,
  output logic                   hk_wr_o,
  output iccm_bus_pkg::mem_req_t hk_req_o,
  output logic                   hk_busy_o,
  output logic                   hk_done_o
);
  import iccm_bus_pkg::*;
  import boot_ctrl_pkg::*;

  localparam int BIT_CW = $clog2(`WORD_W);

  logic [`HK_SYNC_STAGES-1:0] sck_sync_q;
  logic [`HK_SYNC_STAGES-1:0] sdi_sync_q;
  logic [`HK_SYNC_STAGES-1:0] csb_sync_q;
  logic                       sck_s;
  logic                       sdi_s;
  logic                       csb_s;
  logic                       sck_prev_q;
  logic                       sck_rise;

  hk_state_e                  state_q;
  hk_state_e                  state_d;
  logic [BIT_CW-1:0]          bit_cnt_q;
  word_t                      shift_q;
  iccm_addr_t                 wr_addr_q;
  logic                       got_word_q;
  logic                       done_q;

  //////////////////////////////////////////////////
  // Pin synchronizers
  //////////////////////////////////////////////////

  // csb idles high so the loader starts outside a session
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sck_sync_q <= '0;
      sdi_sync_q <= '0;
      csb_sync_q <= '1;
      sck_prev_q <= 1'b0;
    end else begin
      sck_sync_q <= {sck_sync_q[`HK_SYNC_STAGES-2:0], hk_sck_i};
      sdi_sync_q <= {sdi_sync_q[`HK_SYNC_STAGES-2:0], hk_sdi_i};
      csb_sync_q <= {csb_sync_q[`HK_SYNC_STAGES-2:0], hk_csb_i};
      sck_prev_q <= sck_s;
    end
  end

  assign sck_s    = sck_sync_q[`HK_SYNC_STAGES-1];
  assign sdi_s    = sdi_sync_q[`HK_SYNC_STAGES-1];
  assign csb_s    = csb_sync_q[`HK_SYNC_STAGES-1];
  assign sck_rise = sck_s & ~sck_prev_q;

  //////////////////////////////////////////////////
  // Session FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      HK_IDLE: begin
        if (!csb_s) begin
          state_d = HK_SHIFT;
        end
      end
      HK_SHIFT: begin
        // Leaving mid-word drops the partial word
        if (csb_s) begin
          state_d = HK_IDLE;
        end else if (sck_rise && bit_cnt_q == BIT_CW'(`WORD_W - 1)) begin
          state_d = HK_COMMIT;
        end
      end
      HK_COMMIT: state_d = HK_SHIFT;
      default:   state_d = HK_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= HK_IDLE;
      bit_cnt_q  <= '0;
      wr_addr_q  <= '0;
      got_word_q <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      case (state_q)
        HK_IDLE: begin
          // New session restarts at address 0 and clears done
          if (!csb_s) begin
            bit_cnt_q  <= '0;
            wr_addr_q  <= '0;
            got_word_q <= 1'b0;
            done_q     <= 1'b0;
          end
        end
        HK_SHIFT: begin
          if (csb_s) begin
            done_q <= got_word_q;
          end else if (sck_rise) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end
        end
        HK_COMMIT: begin
          wr_addr_q  <= wr_addr_q + 1'b1;
          got_word_q <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  // MSB first
  always_ff @(posedge clk_i) begin
    if (state_q == HK_SHIFT && sck_rise) begin
      shift_q <= {shift_q[`WORD_W-2:0], sdi_s};
    end
  end

  always_comb begin
    hk_req_o       = '0;
    hk_req_o.we    = 1'b1;
    hk_req_o.addr  = wr_addr_q;
    hk_req_o.wdata = shift_q;
    hk_req_o.wmask = '1;
  end

  assign hk_wr_o   = (state_q == HK_COMMIT);
  assign hk_busy_o = (state_q != HK_IDLE);
  assign hk_done_o = done_q;

endmodule

`default_nettype wire

/* hdl/iccm_arbiter.sv */
// ICCM arbiter between the SPI loader and the host port
// Loader strobes win, host reads are tracked to a one-cycle valid
`default_nettype none

module iccm_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Loader side
  input  logic                   hk_wr_i,
  input  logic                   hk_busy_i,
  input  iccm_bus_pkg::mem_req_t hk_req_i,
  // Host side
  input  logic                   host_req_i,
  input  iccm_bus_pkg::mem_req_t host_cmd_i,
  output logic                   host_gnt_o,
  output logic                   host_rvalid_o,
  output iccm_bus_pkg::word_t    host_rdata_o,
  // SRAM side
  output logic                   mem_en_o,
  output iccm_bus_pkg::mem_req_t mem_req_o,
  input  iccm_bus_pkg::word_t    mem_rdata_i
);
  import iccm_bus_pkg::*;

  logic host_rd_acc;
  logic rd_pend_q;

  // Host is held off for the whole loader session
  assign host_gnt_o  = host_req_i & ~hk_busy_i;
  assign host_rd_acc = host_gnt_o & ~host_cmd_i.we;

  // Memory port mux, loader first
  always_comb begin
    if (hk_wr_i) begin
      mem_en_o  = 1'b1;
      mem_req_o = hk_req_i;
    end else begin
      mem_en_o  = host_gnt_o;
      mem_req_o = host_cmd_i;
    end
  end

  // One flag per accepted read, back-to-back reads keep it high
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= host_rd_acc;
    end
  end

  assign host_rvalid_o = rd_pend_q;

  // SRAM output register holds the word of the last read
  assign host_rdata_o  = mem_rdata_i;

endmodule

`default_nettype wire

/* hdl/iccm_sram.sv */
// Single-port instruction SRAM
// Byte-masked write and registered read data
`default_nettype none

`include "soc_boot_defines.svh"

module iccm_sram (
  input  logic                   clk_i,
  input  logic                   en_i,
  input  iccm_bus_pkg::mem_req_t req_i,
  output iccm_bus_pkg::word_t    rdata_o
);
  import iccm_bus_pkg::*;

  localparam int BYTE_W = `WORD_W / `MASK_W;

  word_t mem_q [0:`ICCM_DEPTH-1];

  //////////////////////////////////////////////////
  // Array access
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (req_i.we) begin
        // Clear mask bits keep the stored byte
        for (int b = 0; b < `MASK_W; b++) begin
          if (req_i.wmask[b]) begin
            mem_q[req_i.addr][b*BYTE_W +: BYTE_W] <= req_i.wdata[b*BYTE_W +: BYTE_W];
          end
        end
      end else begin
        rdata_o <= mem_q[req_i.addr];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/boot_addr_sel.sv */
// Boot address selector
// Registered choice of ROM, ICCM or QSPI start address
`default_nettype none

`include "soc_boot_defines.svh"

module boot_addr_sel (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     por_n_i,
  input  logic                     boot_sel_i,
  input  logic                     prog_done_i,
  output iccm_bus_pkg::boot_addr_t boot_addr_o
);
  import iccm_bus_pkg::*;
  import boot_ctrl_pkg::*;

  boot_src_e src_q;
  boot_src_e src_d;

  // ROM until a program has been loaded, then the pin picks the region
  always_comb begin
    if (!por_n_i) begin
      src_d = BOOT_ROM;
    end else if (prog_done_i) begin
      src_d = boot_sel_i ? BOOT_QSPI : BOOT_ICCM;
    end else begin
      src_d = BOOT_ROM;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_q <= BOOT_ROM;
    end else begin
      src_q <= src_d;
    end
  end

  always_comb begin
    case (src_q)
      BOOT_ICCM: boot_addr_o = `BOOT_ICCM_BASE;
      BOOT_QSPI: boot_addr_o = `BOOT_QSPI_BASE;
      default:   boot_addr_o = `BOOT_ROM_BASE;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/soc_boot_top.sv */
// Boot and programming slice top level
// SPI loader and host port share the ICCM, plus the boot address selector
`default_nettype none

module soc_boot_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     por_n_i,
  input  logic                     boot_sel_i,
  // Housekeeping SPI
  input  logic                     hk_sck_i,
  input  logic                     hk_sdi_i,
  input  logic                     hk_csb_i,
  output logic                     hk_sdo_o,
  // Host port
  input  logic                     host_req_i,
  input  iccm_bus_pkg::mem_req_t   host_cmd_i,
  output logic                     host_gnt_o,
  output logic                     host_rvalid_o,
  output iccm_bus_pkg::word_t      host_rdata_o,
  // Start address for the core
  output iccm_bus_pkg::boot_addr_t boot_addr_o
);
  import iccm_bus_pkg::*;

  // Loader to arbiter
  logic     hk_wr;
  logic     hk_busy;
  mem_req_t hk_req;

  // Arbiter to SRAM
  logic     mem_en;
  mem_req_t mem_req;
  word_t    mem_rdata;

  //////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////

  // hk_sdo_o reports a finished load and also steers the boot address
  hk_spi_loader u_hk_spi_loader (
    .clk_i     ( clk_i    ),
    .rst_n_i   ( rst_n_i  ),
    .hk_sck_i  ( hk_sck_i ),
    .hk_sdi_i  ( hk_sdi_i ),
    .hk_csb_i  ( hk_csb_i ),
    .hk_wr_o   ( hk_wr    ),
    .hk_req_o  ( hk_req   ),
    .hk_busy_o ( hk_busy  ),
    .hk_done_o ( hk_sdo_o )
  );

  iccm_arbiter u_iccm_arbiter (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .hk_wr_i       ( hk_wr         ),
    .hk_busy_i     ( hk_busy       ),
    .hk_req_i      ( hk_req        ),
    .host_req_i    ( host_req_i    ),
    .host_cmd_i    ( host_cmd_i    ),
    .host_gnt_o    ( host_gnt_o    ),
    .host_rvalid_o ( host_rvalid_o ),
    .host_rdata_o  ( host_rdata_o  ),
    .mem_en_o      ( mem_en        ),
    .mem_req_o     ( mem_req       ),
    .mem_rdata_i   ( mem_rdata     )
  );

  iccm_sram u_iccm_sram (
    .clk_i   ( clk_i     ),
    .en_i    ( mem_en    ),
    .req_i   ( mem_req   ),
    .rdata_o ( mem_rdata )
  );

  boot_addr_sel u_boot_addr_sel (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .por_n_i     ( por_n_i     ),
    .boot_sel_i  ( boot_sel_i  ),
    .prog_done_i ( hk_sdo_o    ),
    .boot_addr_o ( boot_addr_o )
  );

endmodule

`default_nettype wire

/* bench/tb_clk_gen.sv */
// Testbench clock and reset source
// 8 ns clock, reset held low for 16 cycles
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Released just after the 16th rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* bench/soc_boot_asserts.sv */
// Concurrent checks on the boot slice top level
// Grant lockout, read valid timing and loader write strobes
`default_nettype none

module soc_boot_asserts (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   hk_wr_i,
  input logic                   hk_busy_i,
  input logic                   host_gnt_i,
  input logic                   host_rvalid_i,
  input iccm_bus_pkg::mem_req_t host_cmd_i
);
  timeunit 1ns;
  timeprecision 100ps;
  import iccm_bus_pkg::*;

  int unsigned fail_cnt = 0;
  logic        host_rd;

  assign host_rd = host_gnt_i & ~host_cmd_i.we;

  // No host access while the loader owns the memory
  gnt_not_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(host_gnt_i && hk_busy_i))
    else begin
      fail_cnt++;
      $error("host grant while loader busy");
    end

  //////////////////////////////////////////////////
  // Read valid exactly one cycle after the grant
  //////////////////////////////////////////////////

  rd_gives_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_rd |=> host_rvalid_i)
    else begin
      fail_cnt++;
      $error("granted read without valid");
    end

  valid_needs_rd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_rvalid_i |-> $past(host_rd))
    else begin
      fail_cnt++;
      $error("read valid without granted read");
    end

  // Loader writes only inside a session
  wr_in_session: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    hk_wr_i |-> hk_busy_i)
    else begin
      fail_cnt++;
      $error("loader write outside session");
    end

endmodule

bind soc_boot_top soc_boot_asserts u_asserts (
  .clk_i         ( clk_i         ),
  .rst_n_i       ( rst_n_i       ),
  .hk_wr_i       ( hk_wr         ),
  .hk_busy_i     ( hk_busy       ),
  .host_gnt_i    ( host_gnt_o    ),
  .host_rvalid_i ( host_rvalid_o ),
  .host_cmd_i    ( host_cmd_i    )
);

`default_nettype wire

/* bench/tb_soc_boot.sv */
// Directed testbench for the boot slice
// SPI bit driver, host port tasks, reference memory and result counts
`default_nettype none

`include "soc_boot_defines.svh"

module tb_soc_boot;
  timeunit 1ns;
  timeprecision 100ps;
  import iccm_bus_pkg::*;

  localparam int SPI_HALF    = 6;
  localparam int GNT_LIMIT   = 40;
  localparam int SDO_LIMIT   = 4;
  localparam int RESET_LIMIT = 40;

  logic       clk;
  logic       rst_n;
  logic       por_n;
  logic       boot_sel;
  logic       hk_sck;
  logic       hk_sdi;
  logic       hk_csb;
  logic       hk_sdo;
  logic       host_req;
  mem_req_t   host_cmd;
  logic       host_gnt;
  logic       host_rvalid;
  word_t      host_rdata;
  boot_addr_t boot_addr;

  word_t  ref_mem [0:`ICCM_DEPTH-1];
  integer seed;
  int     errors;
  int     checks;
  logic   watch_gnt;

  tb_clk_gen u_clk_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  soc_boot_top dut_i (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .por_n_i       ( por_n       ),
    .boot_sel_i    ( boot_sel    ),
    .hk_sck_i      ( hk_sck      ),
    .hk_sdi_i      ( hk_sdi      ),
    .hk_csb_i      ( hk_csb      ),
    .hk_sdo_o      ( hk_sdo      ),
    .host_req_i    ( host_req    ),
    .host_cmd_i    ( host_cmd    ),
    .host_gnt_o    ( host_gnt    ),
    .host_rvalid_o ( host_rvalid ),
    .host_rdata_o  ( host_rdata  ),
    .boot_addr_o   ( boot_addr   )
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Inputs change and outputs are read 1 ns after the edge
  task automatic tick();
    @(posedge clk);
    #1;
    if (watch_gnt && host_gnt) begin
      errors++;
      $display("FAILED %0t: host granted during SPI session", $time);
    end
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                        input wmask_t mask);
    word_t res;
    res = old_w;
    for (int b = 0; b < `MASK_W; b++) begin
      if (mask[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic wait_grant(input string what);
    int n;
    n = 0;
    // Grant is combinational and is sampled once the request has settled
    #1;
    while (!host_gnt && n < GNT_LIMIT) begin
      tick();
      n++;
    end
    if (!host_gnt) begin
      errors++;
      $display("Timeout: %s was never granted", what);
    end
  endtask

  task automatic wait_sdo(input logic val, input string what);
    int n;
    n = 0;
    while (hk_sdo !== val && n < SDO_LIMIT) begin
      tick();
      n++;
    end
    check_word(what, word_t'(hk_sdo), word_t'(val));
  endtask

  task automatic host_write(input iccm_addr_t addr, input word_t data, input wmask_t mask);
    host_cmd = {1'b1, addr, data, mask};
    host_req = 1'b1;
    wait_grant("host write");
    tick();
    host_req = 1'b0;
    ref_mem[addr] = merge_bytes(ref_mem[addr], data, mask);
  endtask

  task automatic expect_read(input iccm_addr_t addr);
    checks++;
    if (!host_rvalid) begin
      errors++;
      $display("FAILED %0t: no read valid for address %0d", $time, addr);
    end
    check_word("read data", host_rdata, ref_mem[addr]);
  endtask

  task automatic start_read(input iccm_addr_t addr);
    host_cmd = {1'b0, addr, word_t'(0), wmask_t'(0)};
    host_req = 1'b1;
  endtask

  // Second read is accepted while the first one returns
  task automatic host_read_pair(input iccm_addr_t a0, input iccm_addr_t a1);
    start_read(a0);
    wait_grant("first read");
    tick();
    host_cmd.addr = a1;
    expect_read(a0);
    check_word("back-to-back grant", word_t'(host_gnt), 32'd1);
    tick();
    host_req = 1'b0;
    expect_read(a1);
    tick();
    check_word("valid after burst", word_t'(host_rvalid), 32'd0);
  endtask

  // MSB first with sdi set up half a period before sck rises
  task automatic spi_shift(input word_t data, input int nbits);
    for (int i = nbits - 1; i >= 0; i--) begin
      hk_sdi = data[i];
      repeat (SPI_HALF) tick();
      hk_sck = 1'b1;
      repeat (SPI_HALF) tick();
      hk_sck = 1'b0;
    end
  endtask

  task automatic report(input string name, input int start_err);
    if (errors == start_err) begin
      $display("Test %s: passed", name);
    end else begin
      $display("Test %s: failed with %0d errors", name, errors - start_err);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset_values();
    int start_err;
    start_err = errors;
    check_word("host_gnt_o", word_t'(host_gnt), 32'd0);
    check_word("host_rvalid_o", word_t'(host_rvalid), 32'd0);
    check_word("hk_sdo_o", word_t'(hk_sdo), 32'd0);
    check_word("boot address", boot_addr, `BOOT_ROM_BASE);
    report("reset values", start_err);
  endtask

  task automatic test_boot_before_load();
    int start_err;
    start_err = errors;
    por_n = 1'b0;
    tick();
    check_word("boot address, por low", boot_addr, `BOOT_ROM_BASE);
    por_n = 1'b1;
    boot_sel = 1'b1;
    tick();
    check_word("boot address, no program", boot_addr, `BOOT_ROM_BASE);
    boot_sel = 1'b0;
    tick();
    check_word("boot address, no program", boot_addr, `BOOT_ROM_BASE);
    report("boot before load", start_err);
  endtask

  task automatic test_masked_writes();
    wmask_t masks [6];
    int     start_err;
    start_err = errors;
    masks = '{4'b0001, 4'b0110, 4'b1010, 4'b0000, 4'b1000, 4'b0101};
    for (int a = 0; a < 6; a++) begin
      host_write(iccm_addr_t'(a), $random(seed), 4'b1111);
    end
    for (int a = 0; a < 6; a++) begin
      host_write(iccm_addr_t'(a), $random(seed), masks[a]);
    end
    host_read_pair(0, 1);
    host_read_pair(2, 3);
    host_read_pair(4, 5);
    report("masked writes", start_err);
  endtask

  task automatic test_spi_load();
    word_t w;
    int    start_err;
    start_err = errors;
    hk_csb = 1'b0;
    repeat (SPI_HALF) tick();
    for (int i = 0; i < 5; i++) begin
      w = $random(seed);
      spi_shift(w, 32);
      ref_mem[i] = w;
    end
    // Trailing partial word is dropped
    spi_shift($random(seed), 7);
    repeat (SPI_HALF) tick();
    check_word("hk_sdo_o during session", word_t'(hk_sdo), 32'd0);
    hk_csb = 1'b1;
    wait_sdo(1'b1, "hk_sdo_o after session");
    host_read_pair(0, 1);
    host_read_pair(2, 3);
    host_read_pair(4, 5);
    report("spi load", start_err);
  endtask

  task automatic test_boot_after_load();
    int start_err;
    start_err = errors;
    boot_sel = 1'b0;
    tick();
    check_word("boot address, iccm", boot_addr, `BOOT_ICCM_BASE);
    boot_sel = 1'b1;
    tick();
    check_word("boot address, qspi", boot_addr, `BOOT_QSPI_BASE);
    boot_sel = 1'b0;
    por_n    = 1'b0;
    tick();
    check_word("boot address, por low after load", boot_addr, `BOOT_ROM_BASE);
    por_n = 1'b1;
    tick();
    check_word("boot address, por released", boot_addr, `BOOT_ICCM_BASE);
    report("boot after load", start_err);
  endtask

  task automatic test_held_host();
    word_t w;
    int    start_err;
    start_err = errors;
    hk_csb = 1'b0;
    wait_sdo(1'b0, "hk_sdo_o at session start");
    watch_gnt = 1'b1;
    start_read(0);
    repeat (SPI_HALF) tick();
    w = $random(seed);
    spi_shift(w, 32);
    ref_mem[0] = w;
    repeat (SPI_HALF) tick();
    hk_csb = 1'b1;
    watch_gnt = 1'b0;
    wait_grant("held read");
    tick();
    host_req = 1'b0;
    expect_read(0);
    wait_sdo(1'b1, "hk_sdo_o after second session");
    report("held host request", start_err);
  endtask

  initial begin
    int n;
    seed      = 32'h2445;
    errors    = 0;
    checks    = 0;
    watch_gnt = 1'b0;
    por_n     = 1'b0;
    boot_sel  = 1'b0;
    hk_sck    = 1'b0;
    hk_sdi    = 1'b0;
    hk_csb    = 1'b1;
    host_req  = 1'b0;
    host_cmd  = '0;

    n = 0;
    while (!rst_n && n < RESET_LIMIT) begin
      tick();
      n++;
    end
    if (!rst_n) begin
      errors++;
      $display("Reset was never released");
    end

    test_reset_values();
    test_boot_before_load();
    test_masked_writes();
    test_spi_load();
    test_boot_after_load();
    test_held_host();

    if (dut_i.u_asserts.fail_cnt != 0) begin
      errors++;
      $display("Bound assertions fired %0d times", dut_i.u_asserts.fail_cnt);
    end
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hdl
hdl/iccm_bus_pkg.sv
hdl/boot_ctrl_pkg.sv
hdl/hk_spi_loader.sv
hdl/iccm_arbiter.sv
hdl/iccm_sram.sv
hdl/boot_addr_sel.sv
hdl/soc_boot_top.sv
bench/tb_clk_gen.sv
bench/soc_boot_asserts.sv
bench/tb_soc_boot.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_soc_boot
FILELIST  := sources.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
VFLAGS    += --top-module $(TOP) -Mdir $(OBJ_DIR)
SIM_ARGS  := +verilator+error+limit+1000
PASS_MSG  := ALL CHECKS PASSED

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
